// File: project.f
rtl/l15_bridge_pkg.sv
rtl/l15_req_if.sv
rtl/req_queue.sv
rtl/req_arbiter.sv
rtl/ret_steer.sv
rtl/l15_bridge_top.sv
bench/clk_gen.sv
bench/tb_top.sv

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import l15_bridge_pkg::*;
  ();

  localparam int CLK_PERIOD_NS = 4;
  localparam int REQ_W = RQTYPE_W + 1 + SIZE_W + ADDR_W + DATA_W + AMO_W + WAY_W;
  // Rough cycle count of each test in run order
  localparam int TEST_CYCLES = 8 + 10 + 14 + 12 + 45 + 14;
  localparam int WATCHDOG_NS = (TEST_CYCLES * 4 + 100) * CLK_PERIOD_NS;

  logic clk_i, rst_n_i;
  logic icache_req_v_i, icache_req_ready_o, icache_req_nc_i;
  logic dcache_req_v_i, dcache_req_ready_o, dcache_req_nc_i;
  logic [RQTYPE_W-1:0] icache_req_rqtype_i, dcache_req_rqtype_i, transducer_l15_rqtype_o;
  logic [SIZE_W-1:0]   icache_req_size_i, dcache_req_size_i, transducer_l15_size_o;
  logic [ADDR_W-1:0]   icache_req_address_i, dcache_req_address_i, transducer_l15_address_o;
  logic [DATA_W-1:0]   icache_req_data_i, dcache_req_data_i, transducer_l15_data_o;
  logic [AMO_W-1:0]    icache_req_amo_op_i, dcache_req_amo_op_i, transducer_l15_amo_op_o;
  logic [WAY_W-1:0]    icache_req_l1rplway_i, dcache_req_l1rplway_i, transducer_l15_l1rplway_o;
  logic transducer_l15_val_o, transducer_l15_nc_o, l15_transducer_ack_i;
  logic l15_transducer_val_i;
  logic [RTNTYPE_W-1:0] l15_transducer_returntype_i;
  logic l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i;
  logic l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i;
  logic icache_ret_ready_i, dcache_ret_ready_i, icache_ret_v_o, dcache_ret_v_o;
  logic transducer_l15_req_ack_o, freeze_o;

  logic [31:0] lfsr_q = 32'h231b_36d9;
  int          err_count = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;

  clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) clk_gen_0 (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  l15_bridge_top DUT (.*);

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic random_req(output logic [REQ_W-1:0] r);
    for (int i = 0; i < REQ_W; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      r[i]   = lfsr_q[0];
    end
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before)
    begin
      $display("%s: ok", name);
      tests_ok++;
    end
    else
    begin
      $display("%s: FAILED with %0d errors", name, err_count - errs_before);
      tests_bad++;
    end
  endtask

  task automatic drive_req(input bit to_dcache, input logic v, input logic [REQ_W-1:0] r);
    if (to_dcache)
    begin
      dcache_req_v_i <= v;
      {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
       dcache_req_data_i, dcache_req_amo_op_i, dcache_req_l1rplway_i} <= r;
    end
    else
    begin
      icache_req_v_i <= v;
      {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
       icache_req_data_i, icache_req_amo_op_i, icache_req_l1rplway_i} <= r;
    end
  endtask

  task automatic compare_l15_req(input logic [REQ_W-1:0] r);
    logic [RQTYPE_W-1:0] rqtype;
    logic                nc;
    logic [SIZE_W-1:0]   size;
    logic [ADDR_W-1:0]   address;
    logic [DATA_W-1:0]   data;
    logic [AMO_W-1:0]    amo_op;
    logic [WAY_W-1:0]    l1rplway;
    {rqtype, nc, size, address, data, amo_op, l1rplway} = r;
    expect_eq("transducer_l15_val_o", transducer_l15_val_o, 1'b1);
    expect_eq("transducer_l15_rqtype_o", transducer_l15_rqtype_o, rqtype);
    expect_eq("transducer_l15_nc_o", transducer_l15_nc_o, nc);
    expect_eq("transducer_l15_size_o", transducer_l15_size_o, size);
    expect_eq("transducer_l15_address_o", transducer_l15_address_o, address);
    expect_eq("transducer_l15_data_o", transducer_l15_data_o, data);
    expect_eq("transducer_l15_amo_op_o", transducer_l15_amo_op_o, amo_op);
    expect_eq("transducer_l15_l1rplway_o", transducer_l15_l1rplway_o, l1rplway);
  endtask

  // Leaves the caller at a falling edge with val high
  task automatic wait_for_l15_val(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!transducer_l15_val_o && n < max_cycles)
    begin
      @(negedge clk_i);
      n++;
    end
    assert (transducer_l15_val_o)
    else
    begin
      $display("transducer_l15_val_o never rose within %0d cycles", max_cycles);
      err_count++;
    end
  endtask

  // One ack handshake on the L1.5 request port
  task automatic ack_once();
    @(posedge clk_i);
    l15_transducer_ack_i <= 1'b1;
    @(posedge clk_i);
    l15_transducer_ack_i <= 1'b0;
  endtask

  task automatic reset_state();
    int errs;
    errs = err_count;
    @(negedge clk_i);
    expect_eq("transducer_l15_val_o", transducer_l15_val_o, 1'b0);
    expect_eq("icache_ret_v_o", icache_ret_v_o, 1'b0);
    expect_eq("dcache_ret_v_o", dcache_ret_v_o, 1'b0);
    expect_eq("transducer_l15_req_ack_o", transducer_l15_req_ack_o, 1'b0);
    expect_eq("freeze_o", freeze_o, 1'b1);
    expect_eq("icache_req_ready_o", icache_req_ready_o, 1'b1);
    expect_eq("dcache_req_ready_o", dcache_req_ready_o, 1'b1);
    report_test("reset state", errs);
  endtask

  task automatic single_request();
    logic [REQ_W-1:0] r;
    int errs;
    errs = err_count;
    random_req(r);
    @(posedge clk_i);
    drive_req(0, 1'b1, r);
    @(posedge clk_i);
    icache_req_v_i <= 1'b0;
    wait_for_l15_val(8);
    compare_l15_req(r);
    repeat (3)
    begin
      @(negedge clk_i);
      compare_l15_req(r);
    end
    ack_once();
    @(negedge clk_i);
    expect_eq("transducer_l15_val_o", transducer_l15_val_o, 1'b0);
    report_test("single request", errs);
  endtask

  task automatic priority_order();
    logic [REQ_W-1:0] ri;
    logic [REQ_W-1:0] rd;
    int errs;
    errs = err_count;
    random_req(ri);
    random_req(rd);
    @(posedge clk_i);
    drive_req(0, 1'b1, ri);
    drive_req(1, 1'b1, rd);
    @(posedge clk_i);
    icache_req_v_i <= 1'b0;
    dcache_req_v_i <= 1'b0;
    wait_for_l15_val(8);
    compare_l15_req(rd);
    @(negedge clk_i);
    compare_l15_req(rd);
    ack_once();
    @(negedge clk_i);
    compare_l15_req(ri);
    ack_once();
    @(negedge clk_i);
    expect_eq("transducer_l15_val_o", transducer_l15_val_o, 1'b0);
    report_test("priority", errs);
  endtask

  task automatic backpressure_order();
    logic [REQ_W-1:0] ri;
    logic [REQ_W-1:0] rd;
    logic [REQ_W-1:0] iq[$];
    logic [REQ_W-1:0] dq[$];
    logic [REQ_W-1:0] order[$];
    int errs;
    errs = err_count;
    random_req(ri);
    random_req(rd);
    @(posedge clk_i);
    drive_req(0, 1'b1, ri);
    drive_req(1, 1'b1, rd);
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clk_i);
      expect_eq("icache_req_ready_o", icache_req_ready_o, i < 2);
      expect_eq("dcache_req_ready_o", dcache_req_ready_o, i < 2);
      @(posedge clk_i);
      if (i < 2)
      begin
        iq.push_back(ri);
        dq.push_back(rd);
        random_req(ri);
        random_req(rd);
        drive_req(0, 1'b1, ri);
        drive_req(1, 1'b1, rd);
      end
    end
    @(posedge clk_i);
    icache_req_v_i       <= 1'b0;
    dcache_req_v_i       <= 1'b0;
    l15_transducer_ack_i <= 1'b1;
    order = dq;
    foreach (iq[j])
      order.push_back(iq[j]);
    for (int k = 0; k < 4; k++)
    begin
      @(negedge clk_i);
      compare_l15_req(order[k]);
      @(posedge clk_i);
      if (k == 3)
        l15_transducer_ack_i <= 1'b0;
    end
    @(negedge clk_i);
    expect_eq("transducer_l15_val_o", transducer_l15_val_o, 1'b0);
    report_test("back-pressure and order", errs);
  endtask

  // Flags are icache inval, icache all way, dcache inval, dcache all way
  task automatic steer_case(input logic [3:0] rtype, input logic [3:0] flags,
                            input logic exp_i, input logic exp_d);
    for (int k = 0; k < 4; k++)
    begin
      @(posedge clk_i);
      if (k == 0)
      begin
        l15_transducer_val_i        <= 1'b1;
        l15_transducer_returntype_i <= rtype;
        {l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i,
         l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i} <= flags;
      end
      icache_ret_ready_i <= k[0];
      dcache_ret_ready_i <= k[1];
      @(negedge clk_i);
      expect_eq("icache_ret_v_o", icache_ret_v_o, exp_i);
      expect_eq("dcache_ret_v_o", dcache_ret_v_o, exp_d);
      expect_eq("transducer_l15_req_ack_o", transducer_l15_req_ack_o, k == 3);
    end
    @(posedge clk_i);
    l15_transducer_val_i <= 1'b0;
    {l15_transducer_inval_icache_inval_i, l15_transducer_inval_icache_all_way_i,
     l15_transducer_inval_dcache_inval_i, l15_transducer_inval_dcache_all_way_i} <= 4'b0;
    icache_ret_ready_i <= 1'b0;
    dcache_ret_ready_i <= 1'b0;
  endtask

  task automatic return_steering();
    int errs;
    errs = err_count;
    steer_case(RTN_LOAD, 4'b0000, 1'b0, 1'b1);
    steer_case(RTN_IFILL, 4'b0000, 1'b1, 1'b0);
    steer_case(RTN_ST_ACK, 4'b0000, 1'b0, 1'b1);
    steer_case(RTN_ATOMIC, 4'b0000, 1'b0, 1'b1);
    steer_case(4'd3, 4'b1000, 1'b1, 1'b0);
    steer_case(4'd3, 4'b0100, 1'b1, 1'b0);
    steer_case(4'd3, 4'b0010, 1'b0, 1'b1);
    steer_case(4'd3, 4'b0001, 1'b0, 1'b1);
    steer_case(RTN_IFILL, 4'b0010, 1'b1, 1'b1);
    @(negedge clk_i);
    expect_eq("freeze_o", freeze_o, 1'b1);
    report_test("return steering", errs);
  endtask

  task automatic wakeup_freeze();
    int errs;
    errs = err_count;
    @(posedge clk_i);
    l15_transducer_val_i        <= 1'b1;
    l15_transducer_returntype_i <= RTN_INT;
    @(negedge clk_i);
    expect_eq("transducer_l15_req_ack_o", transducer_l15_req_ack_o, 1'b1);
    expect_eq("icache_ret_v_o", icache_ret_v_o, 1'b0);
    expect_eq("dcache_ret_v_o", dcache_ret_v_o, 1'b0);
    expect_eq("freeze_o", freeze_o, 1'b1);
    @(posedge clk_i);
    l15_transducer_val_i <= 1'b0;
    @(negedge clk_i);
    expect_eq("freeze_o", freeze_o, 1'b0);
    steer_case(RTN_LOAD, 4'b0000, 1'b0, 1'b1);
    steer_case(RTN_IFILL, 4'b0000, 1'b1, 1'b0);
    @(negedge clk_i);
    expect_eq("freeze_o", freeze_o, 1'b0);
    report_test("wakeup", errs);
  endtask

  initial
  begin
    drive_req(0, 1'b0, '0);
    drive_req(1, 1'b0, '0);
    l15_transducer_ack_i = 1'b0;
    l15_transducer_val_i = 1'b0;
    l15_transducer_returntype_i = '0;
    l15_transducer_inval_icache_inval_i = 1'b0;
    l15_transducer_inval_icache_all_way_i = 1'b0;
    l15_transducer_inval_dcache_inval_i = 1'b0;
    l15_transducer_inval_dcache_all_way_i = 1'b0;
    icache_ret_ready_i = 1'b0;
    dcache_ret_ready_i = 1'b0;
    wait (rst_n_i === 1'b1);
    reset_state();
    single_request();
    priority_order();
    backpressure_order();
    return_steering();
    wakeup_freeze();
    $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed");
    $display("sim failed");
    $finish;
  end

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
  #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
  )
  (
  output logic clk_o,
  output logic rst_n_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: rtl/l15_bridge_top.sv
`timescale 1ns/1ps

module l15_bridge_top
  import l15_bridge_pkg::*;
  (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 icache_req_v_i,
  output logic                 icache_req_ready_o,
  input  logic [RQTYPE_W-1:0]  icache_req_rqtype_i,
  input  logic                 icache_req_nc_i,
  input  logic [SIZE_W-1:0]    icache_req_size_i,
  input  logic [ADDR_W-1:0]    icache_req_address_i,
  input  logic [DATA_W-1:0]    icache_req_data_i,
  input  logic [AMO_W-1:0]     icache_req_amo_op_i,
  input  logic [WAY_W-1:0]     icache_req_l1rplway_i,

  input  logic                 dcache_req_v_i,
  output logic                 dcache_req_ready_o,
  input  logic [RQTYPE_W-1:0]  dcache_req_rqtype_i,
  input  logic                 dcache_req_nc_i,
  input  logic [SIZE_W-1:0]    dcache_req_size_i,
  input  logic [ADDR_W-1:0]    dcache_req_address_i,
  input  logic [DATA_W-1:0]    dcache_req_data_i,
  input  logic [AMO_W-1:0]     dcache_req_amo_op_i,
  input  logic [WAY_W-1:0]     dcache_req_l1rplway_i,

  output logic                 transducer_l15_val_o,
  output logic [RQTYPE_W-1:0]  transducer_l15_rqtype_o,
  output logic                 transducer_l15_nc_o,
  output logic [SIZE_W-1:0]    transducer_l15_size_o,
  output logic [ADDR_W-1:0]    transducer_l15_address_o,
  output logic [DATA_W-1:0]    transducer_l15_data_o,
  output logic [AMO_W-1:0]     transducer_l15_amo_op_o,
  output logic [WAY_W-1:0]     transducer_l15_l1rplway_o,
  input  logic                 l15_transducer_ack_i,

  input  logic                 l15_transducer_val_i,
  input  logic [RTNTYPE_W-1:0] l15_transducer_returntype_i,
  input  logic                 l15_transducer_inval_icache_inval_i,
  input  logic                 l15_transducer_inval_icache_all_way_i,
  input  logic                 l15_transducer_inval_dcache_inval_i,
  input  logic                 l15_transducer_inval_dcache_all_way_i,
  input  logic                 icache_ret_ready_i,
  input  logic                 dcache_ret_ready_i,
  output logic                 icache_ret_v_o,
  output logic                 dcache_ret_v_o,
  output logic                 transducer_l15_req_ack_o,

  output logic                 freeze_o
  );

  l15_req_if icache_in_if ();
  l15_req_if dcache_in_if ();
  l15_req_if icache_out_if ();
  l15_req_if dcache_out_if ();

  // Engine ports onto the queue inputs
  assign icache_in_if.v        = icache_req_v_i;
  assign icache_in_if.rqtype   = icache_req_rqtype_i;
  assign icache_in_if.nc       = icache_req_nc_i;
  assign icache_in_if.size     = icache_req_size_i;
  assign icache_in_if.address  = icache_req_address_i;
  assign icache_in_if.data     = icache_req_data_i;
  assign icache_in_if.amo_op   = icache_req_amo_op_i;
  assign icache_in_if.l1rplway = icache_req_l1rplway_i;
  assign icache_req_ready_o    = icache_in_if.ready;

  assign dcache_in_if.v        = dcache_req_v_i;
  assign dcache_in_if.rqtype   = dcache_req_rqtype_i;
  assign dcache_in_if.nc       = dcache_req_nc_i;
  assign dcache_in_if.size     = dcache_req_size_i;
  assign dcache_in_if.address  = dcache_req_address_i;
  assign dcache_in_if.data     = dcache_req_data_i;
  assign dcache_in_if.amo_op   = dcache_req_amo_op_i;
  assign dcache_in_if.l1rplway = dcache_req_l1rplway_i;
  assign dcache_req_ready_o    = dcache_in_if.ready;

  req_queue icache_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_if   (icache_in_if.sink),
    .out_if  (icache_out_if.source)
  );

  req_queue dcache_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_if   (dcache_in_if.sink),
    .out_if  (dcache_out_if.source)
  );

  req_arbiter cmd_arbiter (
    .clk_i                     (clk_i),
    .rst_n_i                   (rst_n_i),
    .icache_if                 (icache_out_if.sink),
    .dcache_if                 (dcache_out_if.sink),
    .transducer_l15_val_o      (transducer_l15_val_o),
    .transducer_l15_rqtype_o   (transducer_l15_rqtype_o),
    .transducer_l15_nc_o       (transducer_l15_nc_o),
    .transducer_l15_size_o     (transducer_l15_size_o),
    .transducer_l15_address_o  (transducer_l15_address_o),
    .transducer_l15_data_o     (transducer_l15_data_o),
    .transducer_l15_amo_op_o   (transducer_l15_amo_op_o),
    .transducer_l15_l1rplway_o (transducer_l15_l1rplway_o),
    .l15_transducer_ack_i      (l15_transducer_ack_i)
  );

  ret_steer ret_steer_0 (
    .clk_i                                 (clk_i),
    .rst_n_i                               (rst_n_i),
    .l15_transducer_val_i                  (l15_transducer_val_i),
    .l15_transducer_returntype_i           (l15_transducer_returntype_i),
    .l15_transducer_inval_icache_inval_i   (l15_transducer_inval_icache_inval_i),
    .l15_transducer_inval_icache_all_way_i (l15_transducer_inval_icache_all_way_i),
    .l15_transducer_inval_dcache_inval_i   (l15_transducer_inval_dcache_inval_i),
    .l15_transducer_inval_dcache_all_way_i (l15_transducer_inval_dcache_all_way_i),
    .icache_ret_ready_i                    (icache_ret_ready_i),
    .dcache_ret_ready_i                    (dcache_ret_ready_i),
    .icache_ret_v_o                        (icache_ret_v_o),
    .dcache_ret_v_o                        (dcache_ret_v_o),
    .transducer_l15_req_ack_o              (transducer_l15_req_ack_o),
    .freeze_o                              (freeze_o)
  );

endmodule

// File: rtl/ret_steer.sv
`timescale 1ns/1ps

module ret_steer
  import l15_bridge_pkg::*;
  (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 l15_transducer_val_i,
  input  logic [RTNTYPE_W-1:0] l15_transducer_returntype_i,
  input  logic                 l15_transducer_inval_icache_inval_i,
  input  logic                 l15_transducer_inval_icache_all_way_i,
  input  logic                 l15_transducer_inval_dcache_inval_i,
  input  logic                 l15_transducer_inval_dcache_all_way_i,
  input  logic                 icache_ret_ready_i,
  input  logic                 dcache_ret_ready_i,
  output logic                 icache_ret_v_o,
  output logic                 dcache_ret_v_o,
  output logic                 transducer_l15_req_ack_o,
  output logic                 freeze_o
  );

  logic int_wakeup;
  logic both_ready;
  logic freeze_q;

  assign int_wakeup = l15_transducer_val_i & (l15_transducer_returntype_i == RTN_INT);

  assign icache_ret_v_o = l15_transducer_val_i
    & (l15_transducer_inval_icache_inval_i
       | l15_transducer_inval_icache_all_way_i
       | (l15_transducer_returntype_i == RTN_IFILL));

  assign dcache_ret_v_o = l15_transducer_val_i
    & (l15_transducer_inval_dcache_inval_i
       | l15_transducer_inval_dcache_all_way_i
       | (l15_transducer_returntype_i inside {RTN_LOAD, RTN_ST_ACK, RTN_ATOMIC}));

  // Invalidates may go to both engines, so wait for both
  assign both_ready = icache_ret_ready_i & dcache_ret_ready_i;

  // Wakeup is acked on its own
  assign transducer_l15_req_ack_o = ((icache_ret_v_o | dcache_ret_v_o) & both_ready)
                                    | int_wakeup;

  // Core held frozen until the first interrupt return
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      freeze_q <= 1'b1;
    else if (int_wakeup)
      freeze_q <= 1'b0;
  end

  assign freeze_o = freeze_q;

  // L1.5 keeps an unacked return in place
  a_ret_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_transducer_val_i && !transducer_l15_req_ack_o
    |=> l15_transducer_val_i && $stable(l15_transducer_returntype_i));

endmodule

// File: rtl/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter
  import l15_bridge_pkg::*;
  (
  input  logic                clk_i,
  input  logic                rst_n_i,
  l15_req_if.sink             icache_if,
  l15_req_if.sink             dcache_if,
  output logic                transducer_l15_val_o,
  output logic [RQTYPE_W-1:0] transducer_l15_rqtype_o,
  output logic                transducer_l15_nc_o,
  output logic [SIZE_W-1:0]   transducer_l15_size_o,
  output logic [ADDR_W-1:0]   transducer_l15_address_o,
  output logic [DATA_W-1:0]   transducer_l15_data_o,
  output logic [AMO_W-1:0]    transducer_l15_amo_op_o,
  output logic [WAY_W-1:0]    transducer_l15_l1rplway_o,
  input  logic                l15_transducer_ack_i
  );

  logic grant_icache;
  logic grant_dcache;

  // Fixed priority with the data cache first
  assign grant_dcache = dcache_if.v;
  assign grant_icache = icache_if.v & ~dcache_if.v;

  assign transducer_l15_val_o = grant_dcache | grant_icache;

  always_comb
  begin
    if (grant_dcache)
    begin
      transducer_l15_rqtype_o   = dcache_if.rqtype;
      transducer_l15_nc_o       = dcache_if.nc;
      transducer_l15_size_o     = dcache_if.size;
      transducer_l15_address_o  = dcache_if.address;
      transducer_l15_data_o     = dcache_if.data;
      transducer_l15_amo_op_o   = dcache_if.amo_op;
      transducer_l15_l1rplway_o = dcache_if.l1rplway;
    end
    else
    begin
      transducer_l15_rqtype_o   = icache_if.rqtype;
      transducer_l15_nc_o       = icache_if.nc;
      transducer_l15_size_o     = icache_if.size;
      transducer_l15_address_o  = icache_if.address;
      transducer_l15_data_o     = icache_if.data;
      transducer_l15_amo_op_o   = icache_if.amo_op;
      transducer_l15_l1rplway_o = icache_if.l1rplway;
    end
  end

  // Pop only the granted head
  assign dcache_if.ready = grant_dcache & l15_transducer_ack_i;
  assign icache_if.ready = grant_icache & l15_transducer_ack_i;

  // L1.5 acks only a presented request
  a_ack_with_val: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_transducer_ack_i |-> transducer_l15_val_o);

endmodule

// File: rtl/req_queue.sv
`timescale 1ns/1ps

module req_queue
  import l15_bridge_pkg::*;
  (
  input logic       clk_i,
  input logic       rst_n_i,
  l15_req_if.sink   in_if,
  l15_req_if.source out_if
  );

  logic [RQTYPE_W-1:0] rqtype_mem   [QUEUE_DEPTH];
  logic                nc_mem       [QUEUE_DEPTH];
  logic [SIZE_W-1:0]   size_mem     [QUEUE_DEPTH];
  logic [ADDR_W-1:0]   address_mem  [QUEUE_DEPTH];
  logic [DATA_W-1:0]   data_mem     [QUEUE_DEPTH];
  logic [AMO_W-1:0]    amo_op_mem   [QUEUE_DEPTH];
  logic [WAY_W-1:0]    l1rplway_mem [QUEUE_DEPTH];

  logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] count_q;
  logic                             push;
  logic                             pop;

  assign in_if.ready = (count_q < QUEUE_DEPTH);
  assign out_if.v    = (count_q != '0);

  assign push = in_if.v & in_if.ready;
  assign pop  = out_if.v & out_if.ready;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      rqtype_mem[wr_ptr_q]   <= in_if.rqtype;
      nc_mem[wr_ptr_q]       <= in_if.nc;
      size_mem[wr_ptr_q]     <= in_if.size;
      address_mem[wr_ptr_q]  <= in_if.address;
      data_mem[wr_ptr_q]     <= in_if.data;
      amo_op_mem[wr_ptr_q]   <= in_if.amo_op;
      l1rplway_mem[wr_ptr_q] <= in_if.l1rplway;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop leaves the count alone
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  // Head entry comes from registers so nothing falls through
  assign out_if.rqtype   = rqtype_mem[rd_ptr_q];
  assign out_if.nc       = nc_mem[rd_ptr_q];
  assign out_if.size     = size_mem[rd_ptr_q];
  assign out_if.address  = address_mem[rd_ptr_q];
  assign out_if.data     = data_mem[rd_ptr_q];
  assign out_if.amo_op   = amo_op_mem[rd_ptr_q];
  assign out_if.l1rplway = l1rplway_mem[rd_ptr_q];

  // Arbiter never pops an empty queue
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_if.ready |-> out_if.v);

endmodule

// File: rtl/l15_req_if.sv
`timescale 1ns/1ps

interface l15_req_if
  import l15_bridge_pkg::*;
  ();

  logic                v;
  logic                ready;
  logic [RQTYPE_W-1:0] rqtype;
  logic                nc;
  logic [SIZE_W-1:0]   size;
  logic [ADDR_W-1:0]   address;
  logic [DATA_W-1:0]   data;
  logic [AMO_W-1:0]    amo_op;
  logic [WAY_W-1:0]    l1rplway;

  // Fields must hold while v is high and ready is low
  modport source (
    output v,
    output rqtype,
    output nc,
    output size,
    output address,
    output data,
    output amo_op,
    output l1rplway,
    input  ready
  );

  modport sink (
    input  v,
    input  rqtype,
    input  nc,
    input  size,
    input  address,
    input  data,
    input  amo_op,
    input  l1rplway,
    output ready
  );

endinterface

// File: rtl/l15_bridge_pkg.sv
package l15_bridge_pkg;

  // L1.5 request field widths
  localparam int ADDR_W    = 40;
  localparam int DATA_W    = 64;
  localparam int RQTYPE_W  = 5;
  localparam int SIZE_W    = 3;
  localparam int AMO_W     = 4;
  localparam int WAY_W     = 2;

  // L1.5 return type field
  localparam int RTNTYPE_W = 4;

  // Two entries so a writeback can queue behind a fill
  localparam int QUEUE_DEPTH = 2;

  // Return type codes from the L1.5
  localparam logic [RTNTYPE_W-1:0] RTN_LOAD   = 4'd0;
  localparam logic [RTNTYPE_W-1:0] RTN_IFILL  = 4'd1;
  localparam logic [RTNTYPE_W-1:0] RTN_ST_ACK = 4'd4;
  localparam logic [RTNTYPE_W-1:0] RTN_INT    = 4'd7;
  localparam logic [RTNTYPE_W-1:0] RTN_ATOMIC = 4'd8;

endpackage
